//--- hdl/mem_rd_pkg.sv
package mem_rd_pkg;

    // Byte address and read data widths.
    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;
    localparam int SIZE_W = 3;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [SIZE_W-1:0] size_t;

    // Access size codes, log2 of the byte count.
    localparam size_t SIZE_BYTE  = 3'd0;
    localparam size_t SIZE_HALF  = 3'd1;
    localparam size_t SIZE_WORD  = 3'd2; // Fetch size.
    localparam size_t SIZE_DWORD = 3'd3;

    // Read request, 67 bits.
    typedef struct packed {
        addr_t addr;
        size_t size;
    } rd_req_t;

endpackage

//--- hdl/mem_rd_arbiter.sv
`timescale 1ns/1ps

module mem_rd_arbiter (
    input  logic                  clk,
    input  logic                  rst,

    // Fetch client.
    input  logic                  fetch_req_valid_i,
    input  mem_rd_pkg::addr_t     fetch_addr_i,
    output logic                  fetch_data_valid_o,
    output mem_rd_pkg::data_t     fetch_data_o,

    // Load client.
    input  logic                  load_req_valid_i,
    input  mem_rd_pkg::rd_req_t   load_req_i,
    output logic                  load_data_valid_o,
    output mem_rd_pkg::data_t     load_data_o,

    // Memory side.
    output logic                  mem_req_valid_o,
    output mem_rd_pkg::rd_req_t   mem_req_o,
    input  logic                  rsp_valid_i,
    input  mem_rd_pkg::data_t     rsp_data_i
);

    typedef enum logic [2:0] {
        IDLE        = 3'b001,
        GRANT_FETCH = 3'b010,
        GRANT_LOAD  = 3'b100
    } arb_state_e;

    arb_state_e state;
    arb_state_e next_state;
    logic       handshake;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Served request, seen one cycle after the data pulse.
    always_ff @(posedge clk) begin
        if (rst) begin
            handshake <= 1'b0;
        end else begin
            handshake <= mem_req_valid_o && rsp_valid_i;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (load_req_valid_i) begin // Load wins from idle.
                    next_state = GRANT_LOAD;
                end else if (fetch_req_valid_i) begin
                    next_state = GRANT_FETCH;
                end
            end
            GRANT_FETCH: begin
                if (handshake) begin
                    if (load_req_valid_i) begin
                        next_state = GRANT_LOAD;
                    end else if (fetch_req_valid_i) begin
                        next_state = GRANT_FETCH;
                    end else begin
                        next_state = IDLE;
                    end
                end
            end
            GRANT_LOAD: begin
                if (handshake) begin
                    if (fetch_req_valid_i) begin
                        next_state = GRANT_FETCH;
                    end else if (load_req_valid_i) begin
                        next_state = GRANT_LOAD;
                    end else begin
                        next_state = IDLE;
                    end
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // Request mux. Nothing is offered to the memory while idle.
    always_comb begin
        case (state)
            GRANT_FETCH: mem_req_valid_o = fetch_req_valid_i;
            GRANT_LOAD:  mem_req_valid_o = load_req_valid_i;
            default:     mem_req_valid_o = 1'b0;
        endcase
        if (state == GRANT_LOAD) begin
            mem_req_o = load_req_i;
        end else begin
            mem_req_o.addr = fetch_addr_i;
            mem_req_o.size = mem_rd_pkg::SIZE_WORD;
        end
    end

    // Data is broadcast, the strobe goes to the grant owner.
    assign fetch_data_o       = rsp_data_i;
    assign load_data_o        = rsp_data_i;
    assign fetch_data_valid_o = (state == GRANT_FETCH) && rsp_valid_i;
    assign load_data_valid_o  = (state == GRANT_LOAD) && rsp_valid_i;

    a_state_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(state));

    a_single_owner: assert property (@(posedge clk) disable iff (rst)
        !(fetch_data_valid_o && load_data_valid_o));

endmodule

//--- hdl/mem_rd_ram.sv
`timescale 1ns/1ps

module mem_rd_ram #(
    parameter int RD_LATENCY = 3,
    parameter int MEM_DWORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  req_valid_i,
    input  mem_rd_pkg::rd_req_t   req_i,
    output logic                  rsp_valid_o,
    output mem_rd_pkg::data_t     rsp_data_o
);

    localparam int IDX_W = $clog2(MEM_DWORDS);
    localparam int CNT_W = $clog2(RD_LATENCY + 1);

    typedef enum logic [1:0] {
        READY,
        BUSY,
        GAP
    } ram_state_e;

    ram_state_e          state;
    logic [CNT_W-1:0]    cnt;
    mem_rd_pkg::rd_req_t req_q;
    mem_rd_pkg::data_t   mem [MEM_DWORDS];
    logic                accept;

    // Byte at address A holds A[7:0] ^ 0x5A, little-endian in a dword.
    function automatic mem_rd_pkg::data_t dword_pattern(int unsigned idx);
        mem_rd_pkg::data_t d;
        logic [7:0]        a;
        for (int b = 0; b < 8; b++) begin
            a = 8'(idx * 8 + b);
            d[b*8 +: 8] = a ^ 8'h5A;
        end
        return d;
    endfunction

    // Shift the addressed bytes down and zero-extend.
    function automatic mem_rd_pkg::data_t extract(mem_rd_pkg::data_t dword,
                                                  logic [2:0] offset,
                                                  mem_rd_pkg::size_t size);
        mem_rd_pkg::data_t shifted;
        shifted = dword >> {offset, 3'b000};
        case (size)
            mem_rd_pkg::SIZE_BYTE: return mem_rd_pkg::data_t'(shifted[7:0]);
            mem_rd_pkg::SIZE_HALF: return mem_rd_pkg::data_t'(shifted[15:0]);
            mem_rd_pkg::SIZE_WORD: return mem_rd_pkg::data_t'(shifted[31:0]);
            default:               return shifted;
        endcase
    endfunction

    assign accept = (state == READY) && req_valid_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_DWORDS; i++) begin
                mem[i] <= dword_pattern(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= READY;
            cnt         <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= 1'b0;
            case (state)
                READY: begin
                    if (req_valid_i) begin
                        state <= BUSY;
                        cnt   <= CNT_W'(RD_LATENCY - 1);
                    end
                end
                BUSY: begin
                    if (cnt == '0) begin
                        state       <= GAP;
                        rsp_valid_o <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                GAP:     state <= READY; // Held request is not taken twice.
                default: state <= READY;
            endcase
        end
    end

    // Captured request and read data.
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
        end
        if (state == BUSY && cnt == '0) begin
            rsp_data_o <= extract(mem[req_q.addr[3 +: IDX_W]], req_q.addr[2:0], req_q.size);
        end
    end

    a_aligned: assert property (@(posedge clk) disable iff (rst)
        accept |-> (req_i.addr[2:0] & ((3'd1 << req_i.size) - 3'd1)) == 3'd0);

    a_size_legal: assert property (@(posedge clk) disable iff (rst)
        req_valid_i |-> req_i.size <= mem_rd_pkg::SIZE_DWORD);

    a_single_pulse: assert property (@(posedge clk) disable iff (rst)
        rsp_valid_o |=> !rsp_valid_o);

endmodule

//--- hdl/mem_rd_top.sv
`timescale 1ns/1ps

module mem_rd_top #(
    parameter int RD_LATENCY = 3,
    parameter int MEM_DWORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  fetch_req_valid_i,
    input  mem_rd_pkg::addr_t     fetch_addr_i,
    output logic                  fetch_data_valid_o,
    output mem_rd_pkg::data_t     fetch_data_o,

    input  logic                  load_req_valid_i,
    input  mem_rd_pkg::rd_req_t   load_req_i,
    output logic                  load_data_valid_o,
    output mem_rd_pkg::data_t     load_data_o
);

    logic                mem_req_valid;
    mem_rd_pkg::rd_req_t mem_req;
    logic                rsp_valid;
    mem_rd_pkg::data_t   rsp_data;

    mem_rd_arbiter arbiter_i (
        .clk                (clk),
        .rst                (rst),
        .fetch_req_valid_i  (fetch_req_valid_i),
        .fetch_addr_i       (fetch_addr_i),
        .fetch_data_valid_o (fetch_data_valid_o),
        .fetch_data_o       (fetch_data_o),
        .load_req_valid_i   (load_req_valid_i),
        .load_req_i         (load_req_i),
        .load_data_valid_o  (load_data_valid_o),
        .load_data_o        (load_data_o),
        .mem_req_valid_o    (mem_req_valid),
        .mem_req_o          (mem_req),
        .rsp_valid_i        (rsp_valid),
        .rsp_data_i         (rsp_data)
    );

    // Single blocking read port.
    mem_rd_ram #(
        .RD_LATENCY (RD_LATENCY),
        .MEM_DWORDS (MEM_DWORDS)
    ) ram_i (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (mem_req_valid),
        .req_i       (mem_req),
        .rsp_valid_o (rsp_valid),
        .rsp_data_o  (rsp_data)
    );

endmodule

//--- dv/mem_rd_tb.sv
`timescale 1ns/1ps

module mem_rd_tb;

    localparam int RD_LATENCY     = 3;
    localparam int MEM_DWORDS     = 256;
    localparam int NUM_REQS       = 1 + 4 + 2 + 16 + 40; // Requests over all tests.
    localparam int TIMEOUT_CYCLES = NUM_REQS * (RD_LATENCY + 8) + 100;

    logic                clk;
    logic                rst;
    logic                fetch_req_valid_i;
    mem_rd_pkg::addr_t   fetch_addr_i;
    logic                fetch_data_valid_o;
    mem_rd_pkg::data_t   fetch_data_o;
    logic                load_req_valid_i;
    mem_rd_pkg::rd_req_t load_req_i;
    logic                load_data_valid_o;
    mem_rd_pkg::data_t   load_data_o;

    int    seed        = 32'hc16;
    int    pass_count  = 0;
    int    error_count = 0;
    int    cycle_count = 0;
    string pulse_log   = ""; // L or F per data-valid pulse.

    mem_rd_top #(
        .RD_LATENCY (RD_LATENCY),
        .MEM_DWORDS (MEM_DWORDS)
    ) dut_i (
        .clk                (clk),
        .rst                (rst),
        .fetch_req_valid_i  (fetch_req_valid_i),
        .fetch_addr_i       (fetch_addr_i),
        .fetch_data_valid_o (fetch_data_valid_o),
        .fetch_data_o       (fetch_data_o),
        .load_req_valid_i   (load_req_valid_i),
        .load_req_i         (load_req_i),
        .load_data_valid_o  (load_data_valid_o),
        .load_data_o        (load_data_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (!rst) begin
            if (load_data_valid_o) pulse_log = {pulse_log, "L"};
            if (fetch_data_valid_o) pulse_log = {pulse_log, "F"};
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    // Byte A of memory is A[7:0] ^ 0x5A, little-endian, zero-extended past the size.
    function automatic mem_rd_pkg::data_t expected_data(mem_rd_pkg::addr_t addr,
                                                        mem_rd_pkg::size_t size);
        mem_rd_pkg::data_t d;
        int                nbytes;
        d      = '0;
        nbytes = 1 << size;
        for (int b = 0; b < nbytes; b++) begin
            d[b*8 +: 8] = 8'(addr + b) ^ 8'h5A;
        end
        return d;
    endfunction

    task automatic check_value(input string name, input mem_rd_pkg::data_t got,
                               input mem_rd_pkg::data_t exp);
        assert (got === exp) pass_count++;
        else begin
            error_count++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pulse_order(input string test_name, input string exp);
        assert (pulse_log == exp) pass_count++;
        else begin
            error_count++;
            $display("Data-valid pulses in %s came as \"%s\" instead of \"%s\"",
                     test_name, pulse_log, exp);
        end
    endtask

    task automatic report_test(input string test_name, input int errors_before);
        $display("Test %s finished, %0d error(s)", test_name, error_count - errors_before);
    endtask

    // Behaves as the fetch client: hold the level until the pulse, drop it a cycle later.
    task automatic fetch_read(input mem_rd_pkg::addr_t addr, output mem_rd_pkg::data_t data);
        @(posedge clk);
        #1;
        fetch_req_valid_i = 1'b1;
        fetch_addr_i      = addr;
        @(negedge clk);
        while (!fetch_data_valid_o) begin
            @(negedge clk);
        end
        data = fetch_data_o;
        @(posedge clk);
        #1;
        fetch_req_valid_i = 1'b0;
    endtask

    task automatic load_read(input mem_rd_pkg::rd_req_t req, output mem_rd_pkg::data_t data);
        @(posedge clk);
        #1;
        load_req_valid_i = 1'b1;
        load_req_i       = req;
        @(negedge clk);
        while (!load_data_valid_o) begin
            @(negedge clk);
        end
        data = load_data_o;
        @(posedge clk);
        #1;
        load_req_valid_i = 1'b0;
    endtask

    task automatic idle_after_reset();
        int errors_before;
        errors_before = error_count;
        repeat (8) begin
            @(negedge clk);
            check_value("fetch_data_valid_o", mem_rd_pkg::data_t'(fetch_data_valid_o), '0);
            check_value("load_data_valid_o", mem_rd_pkg::data_t'(load_data_valid_o), '0);
        end
        report_test("idle_after_reset", errors_before);
    endtask

    task automatic lone_fetch();
        int                errors_before;
        mem_rd_pkg::data_t got;
        errors_before = error_count;
        pulse_log     = "";
        fetch_read(64'h0000_0000_0000_0124, got);
        check_value("fetch_data_o", got, expected_data(64'h124, mem_rd_pkg::SIZE_WORD));
        check_pulse_order("lone_fetch", "F"); // No load pulse allowed.
        report_test("lone_fetch", errors_before);
    endtask

    task automatic lone_loads();
        int                  errors_before;
        mem_rd_pkg::rd_req_t req;
        mem_rd_pkg::data_t   got;
        errors_before = error_count;
        pulse_log     = "";
        for (int s = 0; s < 4; s++) begin
            req.size = mem_rd_pkg::size_t'(s);
            req.addr = (64'h0000_0000_0000_0353 + 64'(s * 40)) & ~((64'd1 << s) - 64'd1);
            load_read(req, got);
            check_value("load_data_o", got, expected_data(req.addr, req.size));
        end
        check_pulse_order("lone_loads", "LLLL");
        report_test("lone_loads", errors_before);
    endtask

    task automatic simultaneous_requests();
        int                  errors_before;
        mem_rd_pkg::rd_req_t req;
        mem_rd_pkg::data_t   got_f;
        mem_rd_pkg::data_t   got_l;
        errors_before = error_count;
        pulse_log     = "";
        req.addr      = 64'h0000_0000_0000_0208;
        req.size      = mem_rd_pkg::SIZE_DWORD;
        fork
            fetch_read(64'h0000_0000_0000_0030, got_f);
            load_read(req, got_l);
        join
        check_value("load_data_o", got_l, expected_data(req.addr, req.size));
        check_value("fetch_data_o", got_f, expected_data(64'h30, mem_rd_pkg::SIZE_WORD));
        check_pulse_order("simultaneous_requests", "LF"); // Load wins from idle.
        report_test("simultaneous_requests", errors_before);
    endtask

    task automatic alternating_rounds();
        int                  errors_before;
        mem_rd_pkg::rd_req_t req;
        mem_rd_pkg::data_t   got_f;
        mem_rd_pkg::data_t   got_l;
        errors_before = error_count;
        pulse_log     = "";
        fork
            for (int i = 0; i < 8; i++) begin
                fetch_read(64'h0000_0000_0000_0400 + 64'(i * 4), got_f);
                check_value("fetch_data_o", got_f,
                            expected_data(64'h400 + 64'(i * 4), mem_rd_pkg::SIZE_WORD));
            end
            for (int j = 0; j < 8; j++) begin
                req.addr = 64'h0000_0000_0000_0600 + 64'(j * 8);
                req.size = mem_rd_pkg::size_t'(j % 4);
                load_read(req, got_l);
                check_value("load_data_o", got_l, expected_data(req.addr, req.size));
            end
        join
        check_pulse_order("alternating_rounds", "LFLFLFLFLFLFLFLF");
        report_test("alternating_rounds", errors_before);
    endtask

    task automatic random_stream();
        int                  errors_before;
        mem_rd_pkg::rd_req_t req;
        mem_rd_pkg::data_t   got;
        logic                use_load;
        errors_before = error_count;
        for (int i = 0; i < 40; i++) begin
            req.addr = {32'($random(seed)), 32'($random(seed))};
            req.size = {1'b0, 2'($random(seed))};
            use_load = 1'($random(seed));
            if (use_load) begin
                req.addr = req.addr & ~((64'd1 << req.size) - 64'd1);
                load_read(req, got);
                check_value("load_data_o", got, expected_data(req.addr, req.size));
            end else begin
                req.addr = req.addr & ~64'd3; // Fetches are always words.
                fetch_read(req.addr, got);
                check_value("fetch_data_o", got, expected_data(req.addr, mem_rd_pkg::SIZE_WORD));
            end
        end
        report_test("random_stream", errors_before);
    endtask

    initial begin
        rst               = 1'b1;
        fetch_req_valid_i = 1'b0;
        fetch_addr_i      = '0;
        load_req_valid_i  = 1'b0;
        load_req_i        = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        idle_after_reset();
        lone_fetch();
        lone_loads();
        simultaneous_requests();
        alternating_rounds();
        random_stream();

        $display("Checks passed: %0d, errors: %0d", pass_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- mem_rd.f
hdl/mem_rd_pkg.sv
hdl/mem_rd_arbiter.sv
hdl/mem_rd_ram.sv
hdl/mem_rd_top.sv
dv/mem_rd_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_rd_tb
FILELIST  ?= mem_rd.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Errors found" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
